/* rtl/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// ************************************************************
// primary opcodes
// ************************************************************
`define DEC_OP_SPECIAL 6'b000000
`define DEC_OP_REGIMM  6'b000001
`define DEC_OP_J       6'b000010
`define DEC_OP_JAL     6'b000011
`define DEC_OP_BEQ     6'b000100
`define DEC_OP_BNE     6'b000101
`define DEC_OP_BLEZ    6'b000110
`define DEC_OP_BGTZ    6'b000111
`define DEC_OP_ADDIU   6'b001001
`define DEC_OP_SLTI    6'b001010
`define DEC_OP_SLTIU   6'b001011
`define DEC_OP_ANDI    6'b001100
`define DEC_OP_ORI     6'b001101
`define DEC_OP_XORI    6'b001110
`define DEC_OP_LUI     6'b001111
`define DEC_OP_LW      6'b100011
`define DEC_OP_SW      6'b101011

// ************************************************************
// funct codes of the SPECIAL group
// ************************************************************
`define DEC_FN_SLL     6'b000000
`define DEC_FN_SRL     6'b000010
`define DEC_FN_SRA     6'b000011
`define DEC_FN_JR      6'b001000
`define DEC_FN_JALR    6'b001001
`define DEC_FN_ADDU    6'b100001
`define DEC_FN_SUBU    6'b100011
`define DEC_FN_AND     6'b100100
`define DEC_FN_OR      6'b100101
`define DEC_FN_XOR     6'b100110
`define DEC_FN_NOR     6'b100111
`define DEC_FN_SLT     6'b101010
`define DEC_FN_SLTU    6'b101011

`define DEC_RT_BLTZ    5'd0      // REGIMM rt selectors
`define DEC_RT_BGEZ    5'd1

`define DEC_LINK_REG    5'd31
`define DEC_LINK_OFFSET 32'd8    // return address lies past the delay slot
`define DEC_BD_OFFSET   32'd4

// conditional branch classes passed from decoder to branch unit
`define DEC_BR_NONE    3'd0
`define DEC_BR_EQ      3'd1
`define DEC_BR_NE      3'd2
`define DEC_BR_GEZ     3'd3
`define DEC_BR_GTZ     3'd4
`define DEC_BR_LEZ     3'd5
`define DEC_BR_LTZ     3'd6

`endif

/* rtl/decode_pkg.sv */
package decode_pkg;

    // ************************************************************
    // architectural widths of the decode stage
    // ************************************************************
    typedef logic [31:0] word_t;      // data or address word
    typedef logic [31:0] inst_t;      // raw instruction word
    typedef logic [4:0]  reg_addr_t;  // gpr number, 0 means no write
    typedef logic [15:0] imm_t;       // immediate or branch offset

    // one-hot alu op, msb first:
    // add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_ctrl_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module inst_decoder import decode_pkg::*; (
    input  inst_t      inst,
    output reg_addr_t  rs,
    output reg_addr_t  rt,
    output logic       rf_wen,
    output reg_addr_t  rf_wdest,
    output alu_ctrl_t  alu_ctrl,
    output logic       need_rs,
    output logic       need_rt,
    output logic       is_jr,
    output logic       is_jump,
    output logic [2:0] branch_kind,
    output logic       link,
    output logic       shf_sa,
    output logic       imm_zero,
    output logic       imm_sign,
    output logic       mem_load,
    output logic       mem_store,
    output logic       reserved
);
    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rd;
    logic [4:0] sa;
    logic       op_special;
    logic       sa_zero;
    logic       rs_zero;
    logic       rt_zero;
    logic i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic i_sll, i_srl, i_sra, i_jr, i_jalr;
    logic i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_j, i_jal;
    logic r_alu;
    logic cond_br;
    logic wdest_rt;
    logic wdest_rd;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign funct = inst[5:0];

    assign op_special = (op == `DEC_OP_SPECIAL);
    assign sa_zero    = (sa == 5'd0);
    assign rs_zero    = (rs == 5'd0);
    assign rt_zero    = (rt == 5'd0);

    // ************************************************************
    // per-instruction match
    // ************************************************************
    assign i_addu  = op_special & sa_zero & (funct == `DEC_FN_ADDU);
    assign i_subu  = op_special & sa_zero & (funct == `DEC_FN_SUBU);
    assign i_slt   = op_special & sa_zero & (funct == `DEC_FN_SLT);
    assign i_sltu  = op_special & sa_zero & (funct == `DEC_FN_SLTU);
    assign i_and   = op_special & sa_zero & (funct == `DEC_FN_AND);
    assign i_or    = op_special & sa_zero & (funct == `DEC_FN_OR);
    assign i_xor   = op_special & sa_zero & (funct == `DEC_FN_XOR);
    assign i_nor   = op_special & sa_zero & (funct == `DEC_FN_NOR);
    assign i_sll   = op_special & rs_zero & (funct == `DEC_FN_SLL);   // shifts leave rs unused
    assign i_srl   = op_special & rs_zero & (funct == `DEC_FN_SRL);
    assign i_sra   = op_special & rs_zero & (funct == `DEC_FN_SRA);
    assign i_jr    = op_special & rt_zero & (rd == 5'd0) & sa_zero & (funct == `DEC_FN_JR);
    assign i_jalr  = op_special & rt_zero & sa_zero & (funct == `DEC_FN_JALR);
    assign i_addiu = (op == `DEC_OP_ADDIU);
    assign i_slti  = (op == `DEC_OP_SLTI);
    assign i_sltiu = (op == `DEC_OP_SLTIU);
    assign i_andi  = (op == `DEC_OP_ANDI);
    assign i_ori   = (op == `DEC_OP_ORI);
    assign i_xori  = (op == `DEC_OP_XORI);
    assign i_lui   = (op == `DEC_OP_LUI) & rs_zero;
    assign i_beq   = (op == `DEC_OP_BEQ);
    assign i_bne   = (op == `DEC_OP_BNE);
    assign i_bgez  = (op == `DEC_OP_REGIMM) & (rt == `DEC_RT_BGEZ);
    assign i_bltz  = (op == `DEC_OP_REGIMM) & (rt == `DEC_RT_BLTZ);
    assign i_bgtz  = (op == `DEC_OP_BGTZ) & rt_zero;
    assign i_blez  = (op == `DEC_OP_BLEZ) & rt_zero;
    assign i_j     = (op == `DEC_OP_J);
    assign i_jal   = (op == `DEC_OP_JAL);
    assign mem_load  = (op == `DEC_OP_LW);
    assign mem_store = (op == `DEC_OP_SW);

    // ************************************************************
    // classes
    // ************************************************************
    assign r_alu    = i_addu | i_subu | i_slt | i_sltu | i_and | i_or | i_xor | i_nor;
    assign shf_sa   = i_sll | i_srl | i_sra;
    assign imm_zero = i_andi | i_ori | i_xori | i_lui;
    assign imm_sign = i_addiu | i_slti | i_sltiu | mem_load | mem_store;
    assign cond_br  = i_beq | i_bne | i_bgez | i_bgtz | i_blez | i_bltz;
    assign is_jr    = i_jr | i_jalr;
    assign is_jump  = i_j | i_jal | is_jr;
    assign link     = i_jal | i_jalr;          // EXE forms pc + 8

    always_comb begin
        branch_kind = `DEC_BR_NONE;
        if (i_beq)       branch_kind = `DEC_BR_EQ;
        else if (i_bne)  branch_kind = `DEC_BR_NE;
        else if (i_bgez) branch_kind = `DEC_BR_GEZ;
        else if (i_bgtz) branch_kind = `DEC_BR_GTZ;
        else if (i_blez) branch_kind = `DEC_BR_LEZ;
        else if (i_bltz) branch_kind = `DEC_BR_LTZ;
    end

    assign alu_ctrl = {i_addu | i_addiu | mem_load | mem_store | link,
                       i_subu,
                       i_slt  | i_slti,
                       i_sltu | i_sltiu,
                       i_and  | i_andi,
                       i_nor,
                       i_or   | i_ori,
                       i_xor  | i_xori,
                       i_sll,
                       i_srl,
                       i_sra,
                       i_lui};

    // source usage, drives the interlock
    assign need_rs = r_alu | (imm_sign) | (imm_zero & ~i_lui) | cond_br | is_jr;
    assign need_rt = r_alu | shf_sa | mem_store | i_beq | i_bne;

    // destination select, 0 when nothing is written
    assign wdest_rt = imm_zero | i_addiu | i_slti | i_sltiu | mem_load;
    assign wdest_rd = r_alu | shf_sa | i_jalr;
    assign rf_wen   = wdest_rt | wdest_rd | i_jal;
    assign rf_wdest = wdest_rt ? rt :
                      i_jal    ? `DEC_LINK_REG :
                      wdest_rd ? rd : 5'd0;

    assign reserved = ~(r_alu | shf_sa | imm_zero | imm_sign | cond_br | is_jump);

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module branch_unit import decode_pkg::*; (
    input  word_t       pc,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  imm_t        offset,
    input  logic [25:0] target26,
    input  logic        is_jr,
    input  logic        is_jump,
    input  logic [2:0]  branch_kind,
    input  logic        in_valid,
    input  logic        in_ready,
    output logic        jbr_taken,
    output word_t       jbr_target
);
    word_t bd_pc;
    word_t j_target;
    word_t br_target;
    logic  rs_eq_rt;
    logic  rs_ez;
    logic  rs_ltz;
    logic  br_cond;

    assign bd_pc = pc + `DEC_BD_OFFSET;    // targets are relative to the delay slot

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == 32'd0);
    assign rs_ltz   = rs_value[31];

    always_comb begin
        case (branch_kind)
            `DEC_BR_EQ:  br_cond = rs_eq_rt;
            `DEC_BR_NE:  br_cond = ~rs_eq_rt;
            `DEC_BR_GEZ: br_cond = ~rs_ltz;
            `DEC_BR_GTZ: br_cond = ~rs_ltz & ~rs_ez;
            `DEC_BR_LEZ: br_cond = rs_ltz | rs_ez;
            `DEC_BR_LTZ: br_cond = rs_ltz;
            default:     br_cond = 1'b0;
        endcase
    end

    assign j_target  = is_jr ? rs_value : {bd_pc[31:28], target26, 2'b00};
    assign br_target = bd_pc + {{14{offset[15]}}, offset, 2'b00};

    // redirect only fires on the accepting cycle
    assign jbr_taken  = (is_jump | br_cond) & in_valid & in_ready;
    assign jbr_target = is_jump ? j_target : br_target;

endmodule

/* rtl/hazard_check.sv */
`timescale 1ns/1ps

module hazard_check import decode_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  reg_addr_t exe_wdest,
    input  reg_addr_t mem_wdest,
    input  reg_addr_t wb_wdest,
    input  logic      need_rs,
    input  logic      need_rt,
    output logic      stall
);
    logic rs_wait;
    logic rt_wait;

    // r0 never waits, pending destinations of 0 mean no write
    assign rs_wait = need_rs & (rs != 5'd0)
                   & ((rs == exe_wdest) | (rs == mem_wdest) | (rs == wb_wdest));
    assign rt_wait = need_rt & (rt != 5'd0)
                   & ((rt == exe_wdest) | (rt == mem_wdest) | (rt == wb_wdest));

    assign stall = rs_wait | rt_wait;

endmodule

/* rtl/operand_select.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module operand_select import decode_pkg::*; (
    input  word_t      pc,
    input  word_t      rs_value,
    input  word_t      rt_value,
    input  imm_t       imm,
    input  logic [4:0] sa,
    input  logic       link,
    input  logic       shf_sa,
    input  logic       imm_zero,
    input  logic       imm_sign,
    output word_t      operand1,
    output word_t      operand2
);
    word_t imm_zext;
    word_t imm_sext;

    assign imm_zext = {16'd0, imm};
    assign imm_sext = {{16{imm[15]}}, imm};

    // link forms pc + 8 in EXE
    assign operand1 = link   ? pc :
                      shf_sa ? {27'd0, sa} : rs_value;

    assign operand2 = link     ? `DEC_LINK_OFFSET :
                      imm_zero ? imm_zext :
                      imm_sign ? imm_sext : rt_value;

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      stall,
    input  logic      ex_ready,
    input  alu_ctrl_t alu_ctrl,
    input  word_t     operand1,
    input  word_t     operand2,
    input  word_t     store_data,
    input  logic      mem_load,
    input  logic      mem_store,
    input  logic      rf_wen,
    input  reg_addr_t rf_wdest,
    input  word_t     pc,
    input  logic      reserved,
    output logic      in_ready,
    output logic      ex_valid,
    output alu_ctrl_t ex_alu_ctrl,
    output word_t     ex_operand1,
    output word_t     ex_operand2,
    output word_t     ex_store_data,
    output logic      ex_mem_load,
    output logic      ex_mem_store,
    output logic      ex_rf_wen,
    output reg_addr_t ex_rf_wdest,
    output word_t     ex_pc,
    output logic      ex_reserved
);
    logic accept;

    // empty slot, or the held item leaves this cycle
    assign in_ready = ~stall & (~ex_valid | ex_ready);
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (accept) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;       // handed off, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_alu_ctrl   <= alu_ctrl;
            ex_operand1   <= operand1;
            ex_operand2   <= operand2;
            ex_store_data <= store_data;
            ex_mem_load   <= mem_load;
            ex_mem_store  <= mem_store;
            ex_rf_wen     <= rf_wen;
            ex_rf_wdest   <= rf_wdest;
            ex_pc         <= pc;
            ex_reserved   <= reserved;
        end
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // fetch side
    input  logic      in_valid,
    output logic      in_ready,
    input  inst_t     in_inst,
    input  word_t     in_pc,
    // register file
    output reg_addr_t rs,
    output reg_addr_t rt,
    input  word_t     rs_value,
    input  word_t     rt_value,
    // pending writes downstream
    input  reg_addr_t exe_wdest,
    input  reg_addr_t mem_wdest,
    input  reg_addr_t wb_wdest,
    // redirect to fetch
    output logic      jbr_taken,
    output word_t     jbr_target,
    // execute side
    output logic      ex_valid,
    input  logic      ex_ready,
    output alu_ctrl_t ex_alu_ctrl,
    output word_t     ex_operand1,
    output word_t     ex_operand2,
    output word_t     ex_store_data,
    output logic      ex_mem_load,
    output logic      ex_mem_store,
    output logic      ex_rf_wen,
    output reg_addr_t ex_rf_wdest,
    output word_t     ex_pc,
    output logic      ex_reserved
);
    logic       rf_wen;
    reg_addr_t  rf_wdest;
    alu_ctrl_t  alu_ctrl;
    logic       need_rs;
    logic       need_rt;
    logic       is_jr;
    logic       is_jump;
    logic [2:0] branch_kind;
    logic       link;
    logic       shf_sa;
    logic       imm_zero;
    logic       imm_sign;
    logic       mem_load;
    logic       mem_store;
    logic       reserved;
    logic       stall;
    word_t      operand1;
    word_t      operand2;

    // ************************************************************
    // decode and resolve
    // ************************************************************
    inst_decoder u_inst_decoder (
        .inst        (in_inst),
        .rs          (rs),
        .rt          (rt),
        .rf_wen      (rf_wen),
        .rf_wdest    (rf_wdest),
        .alu_ctrl    (alu_ctrl),
        .need_rs     (need_rs),
        .need_rt     (need_rt),
        .is_jr       (is_jr),
        .is_jump     (is_jump),
        .branch_kind (branch_kind),
        .link        (link),
        .shf_sa      (shf_sa),
        .imm_zero    (imm_zero),
        .imm_sign    (imm_sign),
        .mem_load    (mem_load),
        .mem_store   (mem_store),
        .reserved    (reserved)
    );

    branch_unit u_branch_unit (
        .pc          (in_pc),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .offset      (in_inst[15:0]),
        .target26    (in_inst[25:0]),
        .is_jr       (is_jr),
        .is_jump     (is_jump),
        .branch_kind (branch_kind),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .jbr_taken   (jbr_taken),
        .jbr_target  (jbr_target)
    );

    hazard_check u_hazard_check (
        .rs        (rs),
        .rt        (rt),
        .exe_wdest (exe_wdest),
        .mem_wdest (mem_wdest),
        .wb_wdest  (wb_wdest),
        .need_rs   (need_rs),
        .need_rt   (need_rt),
        .stall     (stall)
    );

    operand_select u_operand_select (
        .pc       (in_pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .imm      (in_inst[15:0]),
        .sa       (in_inst[10:6]),
        .link     (link),
        .shf_sa   (shf_sa),
        .imm_zero (imm_zero),
        .imm_sign (imm_sign),
        .operand1 (operand1),
        .operand2 (operand2)
    );

    // ************************************************************
    // ID to EXE register
    // ************************************************************
    id_ex_reg u_id_ex_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .stall         (stall),
        .ex_ready      (ex_ready),
        .alu_ctrl      (alu_ctrl),
        .operand1      (operand1),
        .operand2      (operand2),
        .store_data    (rt_value),     // sw stores rt
        .mem_load      (mem_load),
        .mem_store     (mem_store),
        .rf_wen        (rf_wen),
        .rf_wdest      (rf_wdest),
        .pc            (in_pc),
        .reserved      (reserved),
        .in_ready      (in_ready),
        .ex_valid      (ex_valid),
        .ex_alu_ctrl   (ex_alu_ctrl),
        .ex_operand1   (ex_operand1),
        .ex_operand2   (ex_operand2),
        .ex_store_data (ex_store_data),
        .ex_mem_load   (ex_mem_load),
        .ex_mem_store  (ex_mem_store),
        .ex_rf_wen     (ex_rf_wen),
        .ex_rf_wdest   (ex_rf_wdest),
        .ex_pc         (ex_pc),
        .ex_reserved   (ex_reserved)
    );

endmodule

/* tests/decode_chk.sv */
`timescale 1ns/1ps

module decode_chk import decode_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      in_valid,
    input logic      in_ready,
    input logic      jbr_taken,
    input logic      ex_valid,
    input logic      ex_ready,
    input alu_ctrl_t ex_alu_ctrl,
    input word_t     ex_operand1,
    input word_t     ex_operand2,
    input word_t     ex_pc,
    input logic      ex_rf_wen,
    input reg_addr_t ex_rf_wdest
);

    // ************************************************************
    // pipeline register protocol
    // ************************************************************
    a_reset_empty: assert property (@(posedge clk) !rst_n |=> !ex_valid)
        else $error("ex_valid high after a reset cycle");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_alu_ctrl)
            && $stable(ex_operand1) && $stable(ex_operand2) && $stable(ex_pc)
            && $stable(ex_rf_wen) && $stable(ex_rf_wdest))
        else $error("ex payload changed while stalled by EXE");

    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        jbr_taken |-> in_valid && in_ready ##1 ex_valid)    // redirecting item gets loaded
        else $error("jbr_taken without an accepted instruction");

    a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid |-> $onehot0(ex_alu_ctrl))
        else $error("ex_alu_ctrl has more than one bit set");

endmodule

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module tb_decode_stage import decode_pkg::*; ();
    localparam int COLS = 18;               // words per vector

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    inst_t     in_inst;
    word_t     in_pc;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_value;
    word_t     rt_value;
    reg_addr_t exe_wdest;
    reg_addr_t mem_wdest;
    reg_addr_t wb_wdest;
    logic      jbr_taken;
    word_t     jbr_target;
    logic      ex_valid;
    logic      ex_ready;
    alu_ctrl_t ex_alu_ctrl;
    word_t     ex_operand1;
    word_t     ex_operand2;
    word_t     ex_store_data;
    logic      ex_mem_load;
    logic      ex_mem_store;
    logic      ex_rf_wen;
    reg_addr_t ex_rf_wdest;
    word_t     ex_pc;
    logic      ex_reserved;

    logic [31:0] tv [0:1023];
    logic [31:0] hold_alu;
    logic [31:0] hold_op1;
    logic [31:0] hold_op2;
    logic [31:0] hold_wen;
    logic [31:0] hold_wdest;
    logic [31:0] hold_res;
    logic        hold_load;
    logic        hold_store;
    int          nvec;
    int          cycles;
    int          base;
    logic        accepted;

    decode_stage u_decode_stage (.*);

    bind decode_stage decode_chk u_decode_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .jbr_taken   (jbr_taken),
        .ex_valid    (ex_valid),
        .ex_ready    (ex_ready),
        .ex_alu_ctrl (ex_alu_ctrl),
        .ex_operand1 (ex_operand1),
        .ex_operand2 (ex_operand2),
        .ex_pc       (ex_pc),
        .ex_rf_wen   (ex_rf_wen),
        .ex_rf_wdest (ex_rf_wdest)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // ************************************************************
    // run limit
    // ************************************************************
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (nvec > 0 && cycles > 4 * nvec + 30) begin
                $display("Errors found");
                $fatal(1, "the run did not finish within %0d cycles", 4 * nvec + 30);
            end
        end
    end

    // ************************************************************
    // stimulus and checks
    // ************************************************************
    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_inst   = '0;
        in_pc     = '0;
        rs_value  = '0;
        rt_value  = '0;
        exe_wdest = '0;
        mem_wdest = '0;
        wb_wdest  = '0;
        ex_ready  = 1'b0;
        nvec      = 0;
        $readmemh("tests/decode_testdata.txt", tv);
        nvec = int'(tv[0]);
        if (nvec <= 0 || nvec * COLS >= 1023) begin
            $display("Errors found");
            $fatal(1, "the test data file holds no usable vector count");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < nvec; i++) begin
            base      = 1 + i * COLS;
            in_inst   = tv[base + 1];
            in_pc     = tv[base + 2];
            rs_value  = tv[base + 3];
            rt_value  = tv[base + 4];
            exe_wdest = tv[base + 5][4:0];
            mem_wdest = tv[base + 6][4:0];
            wb_wdest  = tv[base + 7][4:0];
            ex_ready  = tv[base + 8][0];
            in_valid  = 1'b1;
            #2;
            check_value("rs", {27'd0, rs}, {27'd0, in_inst[25:21]});
            check_value("rt", {27'd0, rt}, {27'd0, in_inst[20:16]});
            check_value("in_ready", {31'd0, in_ready}, tv[base + 9]);
            check_value("jbr_taken", {31'd0, jbr_taken}, tv[base + 10]);
            if (tv[base][0])
                check_value("jbr_target", jbr_target, tv[base + 11]);
            accepted = tv[base + 9][0];
            @(negedge clk);                  // register loaded on the edge between
            if (accepted) begin
                hold_load  = (in_inst[31:26] == `DEC_OP_LW);
                hold_store = (in_inst[31:26] == `DEC_OP_SW);
                check_value("ex_valid", {31'd0, ex_valid}, 32'd1);
                check_value("ex_alu_ctrl", {20'd0, ex_alu_ctrl}, tv[base + 12]);
                check_value("ex_operand1", ex_operand1, tv[base + 13]);
                check_value("ex_operand2", ex_operand2, tv[base + 14]);
                check_value("ex_rf_wen", {31'd0, ex_rf_wen}, tv[base + 15]);
                check_value("ex_rf_wdest", {27'd0, ex_rf_wdest}, tv[base + 16]);
                check_value("ex_reserved", {31'd0, ex_reserved}, tv[base + 17]);
                check_value("ex_mem_load", {31'd0, ex_mem_load}, {31'd0, hold_load});
                check_value("ex_mem_store", {31'd0, ex_mem_store}, {31'd0, hold_store});
                check_value("ex_pc", ex_pc, in_pc);
                check_value("ex_store_data", ex_store_data, rt_value);
                hold_alu   = tv[base + 12];
                hold_op1   = tv[base + 13];
                hold_op2   = tv[base + 14];
                hold_wen   = tv[base + 15];
                hold_wdest = tv[base + 16];
                hold_res   = tv[base + 17];
            end else if (!ex_ready) begin
                // EXE stalled, previous item must stay put
                check_value("ex_valid", {31'd0, ex_valid}, 32'd1);
                check_value("ex_alu_ctrl", {20'd0, ex_alu_ctrl}, hold_alu);
                check_value("ex_operand1", ex_operand1, hold_op1);
                check_value("ex_operand2", ex_operand2, hold_op2);
                check_value("ex_rf_wen", {31'd0, ex_rf_wen}, hold_wen);
                check_value("ex_rf_wdest", {27'd0, ex_rf_wdest}, hold_wdest);
                check_value("ex_reserved", {31'd0, ex_reserved}, hold_res);
                check_value("ex_mem_load", {31'd0, ex_mem_load}, {31'd0, hold_load});
                check_value("ex_mem_store", {31'd0, ex_mem_store}, {31'd0, hold_store});
            end else begin
                check_value("ex_valid", {31'd0, ex_valid}, 32'd0);
            end
        end
        in_valid = 1'b0;
        @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/branch_unit.sv
rtl/hazard_check.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
tests/decode_chk.sv
tests/tb_decode_stage.sv

/* Makefile */
SRCS := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

obj_dir/Vtb_decode_stage: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_decode_stage \
		-f vlog.f -o Vtb_decode_stage

.PHONY: run clean

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage

clean:
	rm -rf obj_dir

/* tests/decode_testdata.txt */
// first word: vector count. then per line: chk_target inst pc rs_value rt_value exe mem wb ex_ready
// | in_ready jbr_taken jbr_target alu_ctrl operand1 operand2 rf_wen rf_wdest reserved
00000025
0 00221821 00400000 00000005 00000007 00 00 00 1 1 0 00000000 800 00000005 00000007 1 03 0
0 00a62023 00400004 00000010 00000003 00 00 00 1 1 0 00000000 400 00000010 00000003 1 04 0
0 01093827 00400008 f0f0f0f0 0f0f0f0f 00 00 00 1 1 0 00000000 040 f0f0f0f0 0f0f0f0f 1 07 0
0 00025100 0040000c 00000000 12345678 00 00 00 1 1 0 00000000 008 00000004 12345678 1 0a 0
0 00035fc3 00400010 00000000 80000000 00 00 00 1 1 0 00000000 002 0000001f 80000000 1 0b 0
0 2425fffc 00400014 00000100 00000000 00 00 00 1 1 0 00000000 800 00000100 fffffffc 1 05 0
0 34268001 00400018 00000100 00000000 00 00 00 1 1 0 00000000 020 00000100 00008001 1 06 0
0 3c07abcd 0040001c 00000000 00000000 00 00 00 1 1 0 00000000 001 00000000 0000abcd 1 07 0
0 8d28fff8 00400020 00001000 00000000 00 00 00 1 1 0 00000000 800 00001000 fffffff8 1 08 0
0 ad2a000c 00400024 00001000 cafef00d 00 00 00 1 1 0 00000000 800 00001000 0000000c 0 00 0
0 2c628000 00400028 00000001 00000000 00 00 00 1 1 0 00000000 100 00000001 ffff8000 1 02 0
1 10220004 00400100 00000009 00000009 00 00 00 1 1 1 00400114 000 00000009 00000009 0 00 0
1 10220004 00400700 00000001 00000002 00 00 00 1 1 0 00400714 000 00000001 00000002 0 00 0
1 14220004 00400200 00000009 00000009 00 00 00 1 1 0 00400214 000 00000009 00000009 0 00 0
1 14220004 00400800 00000001 00000002 00 00 00 1 1 1 00400814 000 00000001 00000002 0 00 0
1 0461fffe 00400300 00000000 00000000 00 00 00 1 1 1 004002fc 000 00000000 00000000 0 00 0
1 0461fffe 00400900 80000000 00000000 00 00 00 1 1 0 004008fc 000 80000000 00000000 0 00 0
1 0460fffe 00400a00 ffffffff 00000000 00 00 00 1 1 1 004009fc 000 ffffffff 00000000 0 00 0
1 0460fffe 00400400 00000000 00000000 00 00 00 1 1 0 004003fc 000 00000000 00000000 0 00 0
1 1c800001 00400500 00000001 00000000 00 00 00 1 1 1 00400508 000 00000001 00000000 0 00 0
1 1c800001 00400b00 00000000 00000000 00 00 00 1 1 0 00400b08 000 00000000 00000000 0 00 0
1 18800001 00400c00 80000000 00000000 00 00 00 1 1 1 00400c08 000 80000000 00000000 0 00 0
1 18800001 00400600 00000001 00000000 00 00 00 1 1 0 00400608 000 00000001 00000000 0 00 0
1 08100040 00400d00 00000000 00000000 00 00 00 1 1 1 00400100 000 00000000 00000000 0 00 0
1 0fffffff f0000000 00000000 00000000 00 00 00 1 1 1 fffffffc 800 f0000000 00000008 1 1f 0
1 03e00008 00400e00 00400010 00000000 00 00 00 1 1 1 00400010 000 00400010 00000000 0 00 0
1 00404809 00400f00 00500000 00000000 00 00 00 1 1 1 00500000 800 00400f00 00000008 1 09 0
0 00221821 00401000 00000005 00000007 02 00 00 1 0 0 00000000 000 00000000 00000000 0 00 0
0 10220004 00401004 00000005 00000005 00 01 00 1 0 0 00000000 000 00000000 00000000 0 00 0
0 00021821 00401008 00000000 00000002 00 03 04 1 1 0 00000000 800 00000000 00000002 1 03 0
0 3c07abcd 0040100c 00000000 00000000 00 00 07 1 1 0 00000000 001 00000000 0000abcd 1 07 0
0 34268001 00401010 00000100 00000000 06 00 00 1 1 0 00000000 020 00000100 00008001 1 06 0
0 00221821 00401014 00000005 00000007 00 00 00 0 0 0 00000000 000 00000000 00000000 0 00 0
0 10220004 00401018 00000005 00000005 00 00 00 0 0 0 00000000 000 00000000 00000000 0 00 0
0 00a62023 0040101c 00000010 00000003 00 00 00 1 1 0 00000000 400 00000010 00000003 1 04 0
0 fc000000 00401020 00000000 00000000 00 00 00 1 1 0 00000000 000 00000000 00000000 0 00 1
0 00221820 00401024 00000005 00000007 00 00 00 1 1 0 00000000 000 00000005 00000007 0 00 1
